// ==== files.f ====
hdl/FpPipeTypes.sv
hdl/FpOpTypes.sv
hdl/FpRegFileIf.sv
hdl/FpIssueStage.sv
hdl/FpPhyRegFile.sv
hdl/FpRegReadStage.sv
hdl/FpRegReadTop.sv
sim/FpRegReadTb.sv

// ==== hdl/FpIssueStage.sv ====
// FP issue stage
// Captures the issued micro-op each unstalled cycle and decodes which of
// its three operands are read from the register file

`timescale 1ns/10ps

module FpIssueStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         clear,
    input  logic                         issueValid,
    input  FpOpTypes::FpIssuedOp         issueOp,
    output FpOpTypes::FpRegReadRegPath   issueOut
);
    import FpOpTypes::*;

    logic      pipeValid;
    FpIssuedOp pipeOp;
    FpOpInfo   pipeInfo;
    FpOpInfo   decodedInfo;

    // Operand usage per op type
    function automatic FpOpInfo decodeOpInfo(input FpOpType opType);
        FpOpInfo info;
        info.opType = opType;
        info.operandKindA = OK_NONE;
        info.operandKindB = OK_NONE;
        info.operandKindC = OK_NONE;
        case (opType)
            FP_FMA: begin
                info.operandKindA = OK_REG;
                info.operandKindB = OK_REG;
                info.operandKindC = OK_REG;
            end
            FP_ADD, FP_MUL, FP_DIV: begin
                info.operandKindA = OK_REG;
                info.operandKindB = OK_REG;
            end
            FP_SQRT: begin
                info.operandKindA = OK_REG;
            end
            default: begin
                // MOVI carries its value in the op, nothing to read
                info.operandKindA = OK_NONE;
            end
        endcase
        return info;
    endfunction

    always_comb begin
        decodedInfo = decodeOpInfo(issueOp.opType);
    end

    // Valid bit, dropped on clear even while stalled
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= issueValid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp <= issueOp;
            pipeInfo <= decodedInfo;
        end
    end

    // A clear also keeps the read stage from picking up the held op
    always_comb begin
        issueOut.valid = pipeValid && !clear;
        issueOut.op = pipeOp;
        issueOut.info = pipeInfo;
    end

endmodule : FpIssueStage

// ==== hdl/FpOpTypes.sv ====
// FP micro-op types
// Op encodings, operand kinds, the issued micro-op and the issue-to-read
// pipeline register built from them

package FpOpTypes;

    // FP micro-op type
    typedef enum logic [2:0] {
        FP_ADD  = 3'd0,
        FP_MUL  = 3'd1,
        FP_FMA  = 3'd2,
        FP_DIV  = 3'd3,
        FP_SQRT = 3'd4,
        FP_MOVI = 3'd5
    } FpOpType;

    // Where an operand comes from
    typedef enum logic {
        OK_NONE = 1'b0,
        OK_REG  = 1'b1
    } OperandKind;

    // Decoded op info, 6 bits
    typedef struct packed {
        FpOpType    opType;
        OperandKind operandKindA;
        OperandKind operandKindB;
        OperandKind operandKindC;
    } FpOpInfo;

    // Op as it leaves the issue queue
    typedef struct packed {
        FpOpType                  opType;
        FpPipeTypes::PRegNum       srcRegA;
        FpPipeTypes::PRegNum       srcRegB;
        FpPipeTypes::PRegNum       srcRegC;
        FpPipeTypes::PRegNum       dstReg;
        logic                     writeReg;
        FpPipeTypes::ActiveListPtr activePtr;
        FpPipeTypes::OpId          opId;
    } FpIssuedOp;

    // Register between the issue stage and the read stage
    typedef struct packed {
        logic      valid;
        FpIssuedOp op;
        FpOpInfo   info;
    } FpRegReadRegPath;

endpackage : FpOpTypes

// ==== hdl/FpPhyRegFile.sv ====
// Physical FP register file
// 64 data words with one ready bit each. Writeback stores data and marks
// the register ready; allocation marks it not ready. Three combinational
// read ports return data together with the ready bit.

`timescale 1ns/10ps

module FpPhyRegFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                wbEn,
    input  FpPipeTypes::PRegNum wbReg,
    input  FpPipeTypes::FpData  wbData,
    input  logic                allocEn,
    input  FpPipeTypes::PRegNum allocReg,
    FpRegFileIf.RegFile         regs
);
    import FpPipeTypes::*;

    FpData                     dataMem [FP_PHY_REG_NUM];
    logic [FP_PHY_REG_NUM-1:0] readyBits;

    // Data storage
    always_ff @(posedge clk) begin
        if (wbEn) begin
            dataMem[wbReg] <= wbData;
        end
    end

    // Ready bits
    // The writeback assignment comes last so it wins over an allocation
    // of the same register in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            readyBits <= '0;
        end else begin
            if (allocEn) begin
                readyBits[allocReg] <= 1'b0;
            end
            if (wbEn) begin
                readyBits[wbReg] <= 1'b1;
            end
        end
    end

    // Read ports, no write-to-read forwarding
    always_comb begin
        regs.srcDataA.data = dataMem[regs.srcRegA];
        regs.srcDataA.valid = readyBits[regs.srcRegA];

        regs.srcDataB.data = dataMem[regs.srcRegB];
        regs.srcDataB.valid = readyBits[regs.srcRegB];

        regs.srcDataC.data = dataMem[regs.srcRegC];
        regs.srcDataC.valid = readyBits[regs.srcRegC];
    end

endmodule : FpPhyRegFile

// ==== hdl/FpPipeTypes.sv ====
// FP pipeline types
// Physical register file, active list and op id sizes, plus the
// data-and-ready word that travels from the register file to the read stage

package FpPipeTypes;

    // Physical FP register file
    localparam int FP_PHY_REG_NUM = 64;
    localparam int FP_PHY_REG_NUM_BIT_WIDTH = $clog2(FP_PHY_REG_NUM);

    typedef logic [FP_PHY_REG_NUM_BIT_WIDTH-1:0] PRegNum;

    // Register data word
    localparam int FP_DATA_WIDTH = 32;

    typedef logic [FP_DATA_WIDTH-1:0] FpData;

    // Active list, used for the selective flush range
    localparam int ACTIVE_LIST_ENTRY_NUM = 32;
    localparam int ACTIVE_LIST_ENTRY_NUM_BIT_WIDTH = $clog2(ACTIVE_LIST_ENTRY_NUM);

    typedef logic [ACTIVE_LIST_ENTRY_NUM_BIT_WIDTH-1:0] ActiveListPtr;

    // Micro-op id, carried along for tracing
    localparam int OP_ID_WIDTH = 8;

    typedef logic [OP_ID_WIDTH-1:0] OpId;

    // One register read result
    // valid is the ready bit of the register, or forced to 1 by the read
    // stage when the operand is not used
    typedef struct packed {
        FpData data;
        logic  valid;
    } PRegDataPath;

endpackage : FpPipeTypes

// ==== hdl/FpRegFileIf.sv ====
// FP register file read interface
// Three source register numbers go out from the read stage and three
// data-and-ready words come back from the register file

`timescale 1ns/10ps

interface FpRegFileIf;
    import FpPipeTypes::*;

    // Read addresses
    PRegNum srcRegA;
    PRegNum srcRegB;
    PRegNum srcRegC;

    // Read results, combinational from the addresses
    PRegDataPath srcDataA;
    PRegDataPath srcDataB;
    PRegDataPath srcDataC;

    modport ReadStage(
        output srcRegA, srcRegB, srcRegC,
        input  srcDataA, srcDataB, srcDataC
    );

    modport RegFile(
        input  srcRegA, srcRegB, srcRegC,
        output srcDataA, srcDataB, srcDataC
    );

endinterface : FpRegFileIf

// ==== hdl/FpRegReadStage.sv ====
// FP register read stage
// Holds the op coming from the issue stage, reads its three sources,
// marks operands as ready or not, and kills ops caught in a selective
// active-list flush. Flushed divide and square-root ops are reported so
// that the divider reservation can be released.

`timescale 1ns/10ps

module FpRegReadStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       clear,
    input  logic                       flushActive,
    input  FpPipeTypes::ActiveListPtr  flushHead,
    input  FpPipeTypes::ActiveListPtr  flushTail,
    input  FpOpTypes::FpRegReadRegPath issueOut,
    FpRegFileIf.ReadStage              regs,
    output logic                       rrValid,
    output FpOpTypes::FpIssuedOp       rrOp,
    output FpPipeTypes::PRegDataPath   rrOperandA,
    output FpPipeTypes::PRegDataPath   rrOperandB,
    output FpPipeTypes::PRegDataPath   rrOperandC,
    output logic                       rrIsFlushed
);
    import FpPipeTypes::*;
    import FpOpTypes::*;

    logic      pipeValid;
    FpIssuedOp pipeOp;
    FpOpInfo   pipeInfo;
    logic      flush;

    // Circular range check, head inclusive and tail exclusive
    // head == tail is an empty range
    function automatic logic inFlushRange(
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input ActiveListPtr ptr
    );
        logic hit;
        if (head <= tail) begin
            hit = (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the last entry
            hit = (ptr >= head) || (ptr < tail);
        end
        return hit;
    endfunction

    // Pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= issueOut.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp <= issueOut.op;
            pipeInfo <= issueOut.info;
        end
    end

    // Source numbers to the register file
    always_comb begin
        regs.srcRegA = pipeOp.srcRegA;
        regs.srcRegB = pipeOp.srcRegB;
        regs.srcRegC = pipeOp.srcRegC;
    end

    // Operand assembly
    // An unused operand never holds the op back, so its valid is forced high
    always_comb begin
        rrOperandA = regs.srcDataA;
        rrOperandB = regs.srcDataB;
        rrOperandC = regs.srcDataC;
        rrOperandA.valid = (pipeInfo.operandKindA != OK_REG) || regs.srcDataA.valid;
        rrOperandB.valid = (pipeInfo.operandKindB != OK_REG) || regs.srcDataB.valid;
        rrOperandC.valid = (pipeInfo.operandKindC != OK_REG) || regs.srcDataC.valid;
    end

    // Flush and output valid
    always_comb begin
        flush = flushActive && inFlushRange(flushHead, flushTail, pipeOp.activePtr);
        rrValid = (rst || stall || clear || flush) ? 1'b0 : pipeValid;
        rrOp = pipeOp;
    end

    // Divider cancel, reported even while stalled
    always_comb begin
        if (pipeOp.opType inside {FP_DIV, FP_SQRT}) begin
            rrIsFlushed = pipeValid && flush;
        end else begin
            rrIsFlushed = 1'b0;
        end
    end

endmodule : FpRegReadStage

// ==== hdl/FpRegReadTop.sv ====
// FP register read slice
// Issue stage, physical register file and register read stage, joined
// through the register file interface, with plain ports outside

`timescale 1ns/10ps

module FpRegReadTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      clear,
    input  logic                      issueValid,
    input  FpOpTypes::FpOpType        issueOpType,
    input  FpPipeTypes::PRegNum       issueSrcA,
    input  FpPipeTypes::PRegNum       issueSrcB,
    input  FpPipeTypes::PRegNum       issueSrcC,
    input  FpPipeTypes::PRegNum       issueDst,
    input  logic                      issueWriteReg,
    input  FpPipeTypes::ActiveListPtr issueActivePtr,
    input  FpPipeTypes::OpId          issueOpId,
    input  logic                      wbEn,
    input  FpPipeTypes::PRegNum       wbReg,
    input  FpPipeTypes::FpData        wbData,
    input  logic                      allocEn,
    input  FpPipeTypes::PRegNum       allocReg,
    input  logic                      flushActive,
    input  FpPipeTypes::ActiveListPtr flushHead,
    input  FpPipeTypes::ActiveListPtr flushTail,
    output logic                      rrValid,
    output FpOpTypes::FpOpType        rrOpType,
    output FpPipeTypes::OpId          rrOpId,
    output FpPipeTypes::ActiveListPtr rrActivePtr,
    output FpPipeTypes::PRegNum       rrDst,
    output logic                      rrWriteReg,
    output FpPipeTypes::FpData        rrDataA,
    output FpPipeTypes::FpData        rrDataB,
    output FpPipeTypes::FpData        rrDataC,
    output logic                      rrReadyA,
    output logic                      rrReadyB,
    output logic                      rrReadyC,
    output logic                      rrIsFlushed
);
    import FpPipeTypes::*;
    import FpOpTypes::*;

    FpIssuedOp       issueOp;
    FpRegReadRegPath issueOut;
    FpIssuedOp       rrOp;
    PRegDataPath     rrOperandA;
    PRegDataPath     rrOperandB;
    PRegDataPath     rrOperandC;

    FpRegFileIf regFileIf ();

    // Pack the issue inputs
    always_comb begin
        issueOp.opType = issueOpType;
        issueOp.srcRegA = issueSrcA;
        issueOp.srcRegB = issueSrcB;
        issueOp.srcRegC = issueSrcC;
        issueOp.dstReg = issueDst;
        issueOp.writeReg = issueWriteReg;
        issueOp.activePtr = issueActivePtr;
        issueOp.opId = issueOpId;
    end

    FpIssueStage issueStage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .clear      (clear),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueOut   (issueOut)
    );

    FpPhyRegFile phyRegFile (
        .clk      (clk),
        .rst      (rst),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .allocEn  (allocEn),
        .allocReg (allocReg),
        .regs     (regFileIf.RegFile)
    );

    FpRegReadStage regReadStage (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .clear       (clear),
        .flushActive (flushActive),
        .flushHead   (flushHead),
        .flushTail   (flushTail),
        .issueOut    (issueOut),
        .regs        (regFileIf.ReadStage),
        .rrValid     (rrValid),
        .rrOp        (rrOp),
        .rrOperandA  (rrOperandA),
        .rrOperandB  (rrOperandB),
        .rrOperandC  (rrOperandC),
        .rrIsFlushed (rrIsFlushed)
    );

    // Unpack the read stage outputs
    always_comb begin
        rrOpType = rrOp.opType;
        rrOpId = rrOp.opId;
        rrActivePtr = rrOp.activePtr;
        rrDst = rrOp.dstReg;
        rrWriteReg = rrOp.writeReg;
        rrDataA = rrOperandA.data;
        rrDataB = rrOperandB.data;
        rrDataC = rrOperandC.data;
        rrReadyA = rrOperandA.valid;
        rrReadyB = rrOperandB.valid;
        rrReadyC = rrOperandC.valid;
    end

endmodule : FpRegReadTop

// ==== run.sh ====
#!/bin/sh
# Build and run the FP register read testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module FpRegReadTb -f files.f -o FpRegReadSim

output=$(./obj_dir/FpRegReadSim)
echo "$output"

# Exit status follows the search for the pass line
echo "$output" | grep -q "Testbench passed"

// ==== sim/FpRegReadTb.sv ====
// FP register read slice testbench
// Applies a table of per-cycle inputs to the DUT and checks the read stage
// outputs against expected values kept in the same table rows

`timescale 1ns/10ps

module FpRegReadTb;
    import FpPipeTypes::*;
    import FpOpTypes::*;

    localparam int NUM_ROWS = 25;
    localparam int CYCLE_LIMIT = NUM_ROWS + 20;
    localparam ActiveListPtr FLUSH_HEAD = 5'd28;
    localparam ActiveListPtr FLUSH_TAIL = 5'd4;

    // One row per cycle, inputs first and expected outputs after
    // Ready and data mask bits are ordered A, B, C from the top bit down
    typedef struct packed {
        logic         stall;
        logic         clear;
        logic         flush;
        logic         issue;
        FpOpType      opType;
        PRegNum       srcA, srcB, srcC, dst;
        ActiveListPtr ptr;
        OpId          opId;
        logic         writeReg;
        logic         wb;
        PRegNum       wbReg;
        FpData        wbData;
        logic         alloc;
        PRegNum       allocReg;
        logic         expValid;
        logic         expFlushed;
        logic         checkOp;
        FpOpType      expOpType;
        OpId          expOpId;
        ActiveListPtr expPtr;
        PRegNum       expDst;
        logic         expWriteReg;
        FpData        expA, expB, expC;
        logic [2:0]   dataMask;
        logic [2:0]   expReady;
    } TableRow;

    logic clk;
    logic rst;
    logic stall, clear, issueValid, issueWriteReg;
    FpOpType issueOpType;
    PRegNum issueSrcA, issueSrcB, issueSrcC, issueDst;
    ActiveListPtr issueActivePtr;
    OpId issueOpId;
    logic wbEn, allocEn, flushActive;
    PRegNum wbReg, allocReg;
    FpData wbData;
    ActiveListPtr flushHead, flushTail;

    logic rrValid, rrWriteReg, rrReadyA, rrReadyB, rrReadyC, rrIsFlushed;
    FpOpType rrOpType;
    OpId rrOpId;
    ActiveListPtr rrActivePtr;
    PRegNum rrDst;
    FpData rrDataA, rrDataB, rrDataC;

    TableRow stimTable[$];
    FpData dataVal [4];
    integer seed = 32'h263edc4d;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    FpRegReadTop dut (.*);

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, table did not finish", cycleCount);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic setWrite(input int idx, input int regNum, input FpData value);
        TableRow r;
        r = stimTable[idx];
        r.wb = 1'b1;
        r.wbReg = PRegNum'(regNum);
        r.wbData = value;
        stimTable[idx] = r;
    endtask

    task automatic setIssue(input int idx, input FpOpType op, input int a, b, c, dst,
                            input int ptr, id);
        TableRow r;
        r = stimTable[idx];
        r.issue = 1'b1;
        r.opType = op;
        r.srcA = PRegNum'(a);
        r.srcB = PRegNum'(b);
        r.srcC = PRegNum'(c);
        r.dst = PRegNum'(dst);
        r.ptr = ActiveListPtr'(ptr);
        r.opId = OpId'(id);
        r.writeReg = 1'b1;
        stimTable[idx] = r;
    endtask

    task automatic expectOp(input int idx, input FpOpType op, input int id, ptr, dst,
                            input FpData a, b, c, input logic [2:0] mask, ready);
        TableRow r;
        r = stimTable[idx];
        r.expValid = 1'b1;
        r.checkOp = 1'b1;
        r.expOpType = op;
        r.expOpId = OpId'(id);
        r.expPtr = ActiveListPtr'(ptr);
        r.expDst = PRegNum'(dst);
        r.expWriteReg = 1'b1;
        r.expA = a;
        r.expB = b;
        r.expC = c;
        r.dataMask = mask;
        r.expReady = ready;
        stimTable[idx] = r;
    endtask

    // Op issued without a register result, seen with writeReg low
    task automatic dropWrite(input int issueIdx, input int expIdx);
        TableRow r;
        r = stimTable[issueIdx];
        r.writeReg = 1'b0;
        stimTable[issueIdx] = r;
        r = stimTable[expIdx];
        r.expWriteReg = 1'b0;
        stimTable[expIdx] = r;
    endtask

    task automatic buildTable();
        TableRow r;
        r = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            stimTable.push_back(r);
        end
        for (int k = 0; k < 4; k++) begin
            dataVal[k] = $random(seed);
            setWrite(k, k + 1, dataVal[k]);
        end
        // Flush stays high right after reset so a leftover divide would raise rrIsFlushed
        for (int i = 0; i <= 1; i++) begin
            r = stimTable[i];
            r.flush = 1'b1;
            stimTable[i] = r;
        end
        // Register 4 goes back to not ready before anything writes it again
        r = stimTable[4];
        r.alloc = 1'b1;
        r.allocReg = 6'd4;
        stimTable[4] = r;
        // Read path and ready bits
        setIssue(3, FP_FMA, 1, 2, 3, 10, 5, 8'h11);
        setIssue(4, FP_ADD, 1, 4, 0, 11, 6, 8'h12);
        setIssue(5, FP_SQRT, 2, 0, 0, 12, 7, 8'h13);
        setIssue(6, FP_MOVI, 0, 0, 0, 13, 8, 8'h14);
        setIssue(7, FP_MUL, 2, 3, 0, 14, 9, 8'h15);
        setIssue(8, FP_DIV, 3, 2, 0, 15, 10, 8'h16);
        expectOp(5, FP_FMA, 8'h11, 5, 10, dataVal[0], dataVal[1], dataVal[2], 3'b111, 3'b111);
        expectOp(6, FP_ADD, 8'h12, 6, 11, dataVal[0], dataVal[3], 32'h0, 3'b110, 3'b101);
        expectOp(7, FP_SQRT, 8'h13, 7, 12, dataVal[1], 32'h0, 32'h0, 3'b100, 3'b111);
        expectOp(8, FP_MOVI, 8'h14, 8, 13, 32'h0, 32'h0, 32'h0, 3'b000, 3'b111);
        // MUL sits in the read stage through two stall cycles
        for (int i = 9; i <= 10; i++) begin
            r = stimTable[i];
            r.stall = 1'b1;
            stimTable[i] = r;
        end
        expectOp(11, FP_MUL, 8'h15, 9, 14, dataVal[1], dataVal[2], 32'h0, 3'b110, 3'b111);
        expectOp(12, FP_DIV, 8'h16, 10, 15, dataVal[2], dataVal[1], 32'h0, 3'b110, 3'b111);
        dropWrite(5, 7);
        dropWrite(7, 11);
        // Clear kills the ADD in the read stage and the MUL behind it
        setIssue(13, FP_ADD, 1, 2, 0, 16, 11, 8'h17);
        setIssue(14, FP_MUL, 3, 4, 0, 17, 12, 8'h18);
        r = stimTable[15];
        r.clear = 1'b1;
        stimTable[15] = r;
        // Flush window 28 up to 4 wraps through entry 0
        setIssue(16, FP_DIV, 1, 2, 0, 18, 30, 8'h19);
        setIssue(17, FP_ADD, 1, 2, 0, 19, 2, 8'h1A);
        setIssue(18, FP_SQRT, 3, 0, 0, 20, 4, 8'h1B);
        setIssue(19, FP_SQRT, 1, 0, 0, 21, 0, 8'h1C);
        setIssue(20, FP_FMA, 1, 2, 3, 22, 27, 8'h1D);
        for (int i = 18; i <= 22; i++) begin
            r = stimTable[i];
            r.flush = 1'b1;
            r.expFlushed = (i == 18) || (i == 21);
            stimTable[i] = r;
        end
        expectOp(20, FP_SQRT, 8'h1B, 4, 20, dataVal[2], 32'h0, 32'h0, 3'b100, 3'b111);
        expectOp(22, FP_FMA, 8'h1D, 27, 22, dataVal[0], dataVal[1], dataVal[2], 3'b111, 3'b111);
    endtask

    task automatic driveRow(input TableRow r);
        stall = r.stall;
        clear = r.clear;
        flushActive = r.flush;
        issueValid = r.issue;
        issueOpType = r.opType;
        issueSrcA = r.srcA;
        issueSrcB = r.srcB;
        issueSrcC = r.srcC;
        issueDst = r.dst;
        issueWriteReg = r.writeReg;
        issueActivePtr = r.ptr;
        issueOpId = r.opId;
        wbEn = r.wb;
        wbReg = r.wbReg;
        wbData = r.wbData;
        allocEn = r.alloc;
        allocReg = r.allocReg;
    endtask

    task automatic checkRow(input TableRow r);
        compareValue("rrValid", 32'(rrValid), 32'(r.expValid));
        compareValue("rrIsFlushed", 32'(rrIsFlushed), 32'(r.expFlushed));
        if (r.checkOp) begin
            compareValue("rrOpType", 32'(rrOpType), 32'(r.expOpType));
            compareValue("rrOpId", 32'(rrOpId), 32'(r.expOpId));
            compareValue("rrActivePtr", 32'(rrActivePtr), 32'(r.expPtr));
            compareValue("rrDst", 32'(rrDst), 32'(r.expDst));
            compareValue("rrWriteReg", 32'(rrWriteReg), 32'(r.expWriteReg));
            compareValue("rrReadyA", 32'(rrReadyA), 32'(r.expReady[2]));
            compareValue("rrReadyB", 32'(rrReadyB), 32'(r.expReady[1]));
            compareValue("rrReadyC", 32'(rrReadyC), 32'(r.expReady[0]));
            if (r.dataMask[2]) compareValue("rrDataA", rrDataA, r.expA);
            if (r.dataMask[1]) compareValue("rrDataB", rrDataB, r.expB);
            if (r.dataMask[0]) compareValue("rrDataC", rrDataC, r.expC);
        end
    endtask

    initial begin
        TableRow resetRow;
        // A valid divide inside the flush window waits on the inputs during reset
        resetRow = '0;
        resetRow.issue = 1'b1;
        resetRow.opType = FP_DIV;
        resetRow.ptr = 5'd30;
        resetRow.flush = 1'b1;
        clk = 1'b0;
        rst = 1'b1;
        flushHead = FLUSH_HEAD;
        flushTail = FLUSH_TAIL;
        driveRow(resetRow);
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            driveRow(stimTable[i]);
            // Sample just ahead of the next rising edge
            #6;
            checkRow(stimTable[i]);
            @(posedge clk);
            #1;
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : FpRegReadTb
